//--- src/lq_pkg.sv
package lq_pkg;

    localparam int LQ_BANKS   = 2;
    localparam int LQ_DEPTH   = 16;
    localparam int LQ_IDX_W   = 4;
    localparam int BANK_SLOTS = 8;
    localparam int SLOT_W     = 3;
    localparam int PADDR_W    = 32;
    localparam int WORD_BYTES = 8;
    localparam int OFFSET_W   = 3;
    localparam int DATA_W     = 64;
    localparam int REG_W      = 6;
    localparam int CNT_W      = 2;

    typedef struct packed {
        logic                dir;
        logic [LQ_IDX_W-1:0] idx;
    } lq_idx_t;

    // distance from head, one bit wider so a full queue fits
    typedef logic [LQ_IDX_W:0] lq_age_t;

    typedef logic [BANK_SLOTS-1:0] slot_vec_t;
    typedef logic [LQ_BANKS-1:0][BANK_SLOTS-1:0] bank_slot_vec_t;

    typedef struct packed {
        logic                   en;
        logic [SLOT_W-1:0]      slot;
        logic [PADDR_W-1:OFFSET_W] addr;
        logic [WORD_BYTES-1:0]  mask;
        logic                   miss;
        logic [REG_W-1:0]       rd;
    } issue_t;

    typedef struct packed {
        logic              en;
        logic [SLOT_W-1:0] slot;
        logic [DATA_W-1:0] data;
    } refill_t;

    typedef struct packed {
        logic              en;
        logic [REG_W-1:0]  rd;
        logic [DATA_W-1:0] data;
        lq_idx_t           lq_idx;
    } wb_t;

    typedef struct packed {
        logic                      en;
        lq_idx_t                   lq_idx;
        logic [PADDR_W-1:OFFSET_W] addr;
        logic [WORD_BYTES-1:0]     mask;
    } store_chk_t;

    typedef struct packed {
        logic    en;
        lq_idx_t lq_idx;
    } vio_t;

    typedef struct packed {
        logic              en;
        logic [SLOT_W-1:0] slot;
        lq_age_t           age;
    } bank_vio_t;

    function automatic lq_age_t lq_age(lq_idx_t pos, lq_idx_t head);
        return lq_age_t'({pos.dir, pos.idx} - {head.dir, head.idx});
    endfunction

    // live entries sit at or after head, so the wrap bit follows from the index
    function automatic lq_idx_t lq_pos(logic [LQ_IDX_W-1:0] idx, lq_idx_t head);
        lq_idx_t p;
        p.idx = idx;
        p.dir = (idx >= head.idx) ? head.dir : ~head.dir;
        return p;
    endfunction

endpackage

//--- src/lq_alloc.sv
`timescale 1ns/10ps

module lq_alloc import lq_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [CNT_W-1:0]   dis_num_i,
    input  logic [CNT_W-1:0]   commit_num_i,
    output lq_idx_t            head_o,
    output lq_idx_t            tail_o,
    output logic               full_o,
    output bank_slot_vec_t     dis_slot_en_o,
    output bank_slot_vec_t     commit_slot_en_o
);

    lq_idx_t head_q;
    lq_idx_t tail_q;
    lq_age_t used;

    function automatic lq_idx_t advance(lq_idx_t p, logic [CNT_W-1:0] num);
        return lq_idx_t'({p.dir, p.idx} + lq_age_t'(num));
    endfunction

    // mark num consecutive positions starting at base on their bank slots
    function automatic bank_slot_vec_t spread(lq_idx_t base, logic [CNT_W-1:0] num);
        bank_slot_vec_t vec;
        logic [LQ_IDX_W-1:0] pos;
        vec = '0;
        for (int k = 0; k < LQ_BANKS; k++) begin
            pos = base.idx + LQ_IDX_W'(k);
            if (k < int'(num)) begin
                vec[pos % LQ_BANKS][pos / LQ_BANKS] = 1'b1;
            end
        end
        return vec;
    endfunction

    assign used   = lq_age(tail_q, head_q);
    assign full_o = used > lq_age_t'(LQ_DEPTH - LQ_BANKS);

    assign head_o = head_q;
    assign tail_o = tail_q;

    assign dis_slot_en_o    = spread(tail_q, dis_num_i);
    assign commit_slot_en_o = spread(head_q, commit_num_i);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= advance(head_q, commit_num_i);
            tail_q <= advance(tail_q, dis_num_i);
        end
    end

    no_dis_when_full_a: assert property (
        @(posedge clk) disable iff (!rst)
        (dis_num_i != '0) |-> !full_o
    );

    // head must never overtake tail
    commit_in_range_a: assert property (
        @(posedge clk) disable iff (!rst)
        lq_age_t'(commit_num_i) <= used
    );

endmodule

//--- src/lq_bank.sv
`timescale 1ns/10ps

module lq_bank import lq_pkg::*; #(
    parameter int bank_id = 0
) (
    input  logic       clk,
    input  logic       rst,
    input  slot_vec_t  dis_slot_en_i,
    input  slot_vec_t  commit_slot_en_i,
    input  lq_idx_t    head_i,
    input  lq_idx_t    tail_i,
    input  issue_t     issue_i,
    input  refill_t    refill_i,
    input  logic       wb_ready_i,
    input  store_chk_t st_i,
    output wb_t        wb_o,
    output bank_vio_t  vio_o
);

    slot_vec_t valid_q, issued_q, miss_q, refilled_q, written_q;
    slot_vec_t waiting, match;

    logic [PADDR_W-1:OFFSET_W] addr_mem [BANK_SLOTS];
    logic [WORD_BYTES-1:0]     mask_mem [BANK_SLOTS];
    logic [REG_W-1:0]          rd_mem   [BANK_SLOTS];
    logic [DATA_W-1:0]         data_mem [BANK_SLOTS];

    lq_idx_t slot_pos [BANK_SLOTS];
    lq_age_t slot_age [BANK_SLOTS];

    logic              wb_go;
    logic [SLOT_W-1:0] wb_sel;
    logic              wb_en_q;
    logic [REG_W-1:0]  wb_rd_q;
    logic [DATA_W-1:0] wb_data_q;
    lq_idx_t           wb_pos_q;

    lq_age_t           st_age_raw, st_age, tail_age;
    logic              hit_found;
    logic [SLOT_W-1:0] hit_slot;
    lq_age_t           hit_age;
    logic              vio_en_q;
    logic [SLOT_W-1:0] vio_slot_q;
    lq_age_t           vio_age_q;

    always_comb begin
        for (int s = 0; s < BANK_SLOTS; s++) begin
            slot_pos[s] = lq_pos(LQ_IDX_W'(s * LQ_BANKS + bank_id), head_i);
            slot_age[s] = lq_age(slot_pos[s], head_i);
        end
    end

    // missed, refilled, still to write back
    assign waiting = valid_q & issued_q & miss_q & refilled_q & ~written_q;
    assign wb_go   = wb_ready_i & (|waiting);

    always_comb begin
        wb_sel = '0;
        for (int s = BANK_SLOTS - 1; s >= 0; s--) begin
            if (waiting[s]) begin
                wb_sel = SLOT_W'(s);
            end
        end
    end

    // a store behind head means every live load is younger
    assign tail_age   = lq_age(tail_i, head_i);
    assign st_age_raw = lq_age(st_i.lq_idx, head_i);
    assign st_age     = (st_age_raw > tail_age) ? '0 : st_age_raw;

    always_comb begin
        for (int s = 0; s < BANK_SLOTS; s++) begin
            match[s] = st_i.en && valid_q[s] && issued_q[s]
                && slot_age[s] >= st_age && slot_age[s] < tail_age
                && addr_mem[s] == st_i.addr
                && |(mask_mem[s] & st_i.mask);
        end
    end

    // closest to the store wins
    always_comb begin
        hit_found = 1'b0;
        hit_slot  = '0;
        hit_age   = '0;
        for (int s = 0; s < BANK_SLOTS; s++) begin
            if (match[s] && (!hit_found || slot_age[s] < hit_age)) begin
                hit_found = 1'b1;
                hit_slot  = SLOT_W'(s);
                hit_age   = slot_age[s];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q    <= '0;
            issued_q   <= '0;
            miss_q     <= '0;
            refilled_q <= '0;
            written_q  <= '0;
            wb_en_q    <= 1'b0;
            vio_en_q   <= 1'b0;
        end else begin
            valid_q    <= (valid_q | dis_slot_en_i) & ~commit_slot_en_i;
            issued_q   <= issued_q & ~dis_slot_en_i;
            refilled_q <= refilled_q & ~dis_slot_en_i;
            written_q  <= written_q & ~dis_slot_en_i;
            if (issue_i.en) begin
                issued_q[issue_i.slot] <= 1'b1;
                miss_q[issue_i.slot]   <= issue_i.miss;
            end
            if (refill_i.en) begin
                refilled_q[refill_i.slot] <= 1'b1;
            end
            if (wb_go) begin
                written_q[wb_sel] <= 1'b1;
            end
            wb_en_q  <= wb_go;
            vio_en_q <= hit_found;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i.en) begin
            addr_mem[issue_i.slot] <= issue_i.addr;
            mask_mem[issue_i.slot] <= issue_i.mask;
            rd_mem[issue_i.slot]   <= issue_i.rd;
        end
        if (refill_i.en) begin
            data_mem[refill_i.slot] <= refill_i.data;
        end
        if (wb_go) begin
            wb_rd_q   <= rd_mem[wb_sel];
            wb_data_q <= data_mem[wb_sel];
            wb_pos_q  <= slot_pos[wb_sel];
        end
        if (hit_found) begin
            vio_slot_q <= hit_slot;
            vio_age_q  <= hit_age;
        end
    end

    assign wb_o.en     = wb_en_q;
    assign wb_o.rd     = wb_rd_q;
    assign wb_o.data   = wb_data_q;
    assign wb_o.lq_idx = wb_pos_q;

    assign vio_o.en   = vio_en_q;
    assign vio_o.slot = vio_slot_q;
    assign vio_o.age  = vio_age_q;

    issue_valid_a: assert property (
        @(posedge clk) disable iff (!rst)
        issue_i.en |-> valid_q[issue_i.slot]
    );

    refill_miss_a: assert property (
        @(posedge clk) disable iff (!rst)
        refill_i.en |-> issued_q[refill_i.slot] && miss_q[refill_i.slot]
    );

endmodule

//--- src/lq_drain.sv
`timescale 1ns/10ps

module lq_drain import lq_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  lq_idx_t                   head_i,
    input  bank_vio_t [LQ_BANKS-1:0]  bank_vio_i,
    output vio_t                      vio_o
);

    logic                best_en;
    lq_age_t             best_age;
    logic [LQ_IDX_W-1:0] best_idx;
    logic                vio_en_q;
    lq_idx_t             vio_pos_q;

    // smallest age across banks, position is slot * banks + bank
    always_comb begin
        best_en  = 1'b0;
        best_age = '0;
        best_idx = '0;
        for (int b = 0; b < LQ_BANKS; b++) begin
            if (bank_vio_i[b].en && (!best_en || bank_vio_i[b].age < best_age)) begin
                best_en  = 1'b1;
                best_age = bank_vio_i[b].age;
                best_idx = LQ_IDX_W'(int'(bank_vio_i[b].slot) * LQ_BANKS + b);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vio_en_q <= 1'b0;
        end else begin
            vio_en_q <= best_en;
        end
    end

    always_ff @(posedge clk) begin
        if (best_en) begin
            vio_pos_q <= lq_pos(best_idx, head_i);
        end
    end

    assign vio_o.en     = vio_en_q;
    assign vio_o.lq_idx = vio_pos_q;

endmodule

//--- src/load_queue.sv
`timescale 1ns/10ps

module load_queue import lq_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [CNT_W-1:0]          dis_num_i,
    input  logic [CNT_W-1:0]          commit_num_i,
    input  issue_t    [LQ_BANKS-1:0]  issue_i,
    input  refill_t   [LQ_BANKS-1:0]  refill_i,
    input  logic      [LQ_BANKS-1:0]  wb_ready_i,
    input  store_chk_t                st_i,
    output lq_idx_t                   lq_tail_o,
    output logic                      lq_full_o,
    output wb_t       [LQ_BANKS-1:0]  wb_o,
    output vio_t                      vio_o
);

    lq_idx_t                   head;
    lq_idx_t                   tail;
    bank_slot_vec_t            dis_slot_en;
    bank_slot_vec_t            commit_slot_en;
    bank_vio_t [LQ_BANKS-1:0]  bank_vio;

    assign lq_tail_o = tail;

    lq_alloc u_alloc (
        .clk              (clk),
        .rst              (rst),
        .dis_num_i        (dis_num_i),
        .commit_num_i     (commit_num_i),
        .head_o           (head),
        .tail_o           (tail),
        .full_o           (lq_full_o),
        .dis_slot_en_o    (dis_slot_en),
        .commit_slot_en_o (commit_slot_en)
    );

    for (genvar b = 0; b < LQ_BANKS; b++) begin : g_bank
        lq_bank #(
            .bank_id (b)
        ) u_bank (
            .clk              (clk),
            .rst              (rst),
            .dis_slot_en_i    (dis_slot_en[b]),
            .commit_slot_en_i (commit_slot_en[b]),
            .head_i           (head),
            .tail_i           (tail),
            .issue_i          (issue_i[b]),
            .refill_i         (refill_i[b]),
            .wb_ready_i       (wb_ready_i[b]),
            .st_i             (st_i),
            .wb_o             (wb_o[b]),
            .vio_o            (bank_vio[b])
        );
    end

    lq_drain u_drain (
        .clk        (clk),
        .rst        (rst),
        .head_i     (head),
        .bank_vio_i (bank_vio),
        .vio_o      (vio_o)
    );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int half_period = 2
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(half_period) clk_o = ~clk_o;
        end
    end

endmodule

//--- tests/load_queue_tb.sv
`timescale 1ns/10ps

module load_queue_tb import lq_pkg::*; ();

    localparam int CLK_PERIOD    = 4;
    // cycles for reset, dispatch, writeback, back-pressure and the two violation tests
    localparam int TEST_CYCLES   = 8 + 20 + 60 + 70 + 30 + 30;
    localparam int MARGIN_CYCLES = 100;

    typedef logic [PADDR_W-1:OFFSET_W] waddr_t;
    typedef logic [LQ_IDX_W:0]         pos_t;

    logic                      clk;
    logic                      rst;
    logic [CNT_W-1:0]          dis_num;
    logic [CNT_W-1:0]          commit_num;
    issue_t    [LQ_BANKS-1:0]  issue;
    refill_t   [LQ_BANKS-1:0]  refill;
    logic      [LQ_BANKS-1:0]  wb_ready;
    logic      [LQ_BANKS-1:0]  ready_prev;
    store_chk_t                st;
    lq_idx_t                   lq_tail;
    logic                      lq_full;
    wb_t       [LQ_BANKS-1:0]  wb;
    vio_t                      vio;

    // reference model
    pos_t                      m_head;
    pos_t                      m_tail;
    logic                      m_valid    [LQ_DEPTH];
    logic                      m_issued   [LQ_DEPTH];
    logic                      m_miss     [LQ_DEPTH];
    logic                      m_refilled [LQ_DEPTH];
    logic                      m_written  [LQ_DEPTH];
    waddr_t                    m_addr     [LQ_DEPTH];
    logic [WORD_BYTES-1:0]     m_mask     [LQ_DEPTH];
    logic [REG_W-1:0]          m_rd       [LQ_DEPTH];
    logic [DATA_W-1:0]         m_data     [LQ_DEPTH];
    pos_t                      m_pos      [LQ_DEPTH];

    int value_errs;
    int other_errs;
    int wb_seen;
    int seed = 11816;

    tb_clock #(.half_period(CLK_PERIOD / 2)) clk_gen (.clk_o(clk));

    load_queue dut0 (
        .clk          (clk),
        .rst          (rst),
        .dis_num_i    (dis_num),
        .commit_num_i (commit_num),
        .issue_i      (issue),
        .refill_i     (refill),
        .wb_ready_i   (wb_ready),
        .st_i         (st),
        .lq_tail_o    (lq_tail),
        .lq_full_o    (lq_full),
        .wb_o         (wb),
        .vio_o        (vio)
    );

    task automatic expect_value(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
        assert (got == exp) else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic expect_true(logic cond, string what);
        assert (cond) else begin
            $display("ERROR: %s", what);
            other_errs++;
        end
    endtask

    function automatic int qpos(int base, int k);
        return (base + k) % LQ_DEPTH;
    endfunction

    // missed, refilled and not yet written back
    function automatic logic waiting(int i);
        return m_valid[i] && m_issued[i] && m_miss[i] && m_refilled[i] && !m_written[i];
    endfunction

    function automatic int waiting_count(int bank);
        int c = 0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (waiting(i) && (bank < 0 || i % LQ_BANKS == bank)) begin
                c++;
            end
        end
        return c;
    endfunction

    task automatic check_wb();
        int i;
        for (int b = 0; b < LQ_BANKS; b++) begin
            if (wb[b].en) begin
                i = int'(wb[b].lq_idx.idx);
                wb_seen++;
                expect_true(ready_prev[b], "writeback while that bank's wb_ready was low");
                expect_true(i % LQ_BANKS == b, "writeback came out of the wrong bank");
                expect_true(waiting(i), "writeback of a load that was not waiting");
                expect_value("wb_o.rd", wb[b].rd, m_rd[i]);
                expect_value("wb_o.data", wb[b].data, m_data[i]);
                expect_value("wb_o.lq_idx", wb[b].lq_idx, m_pos[i]);
                m_written[i] = 1'b1;
            end
        end
    endtask

    // one cycle up to the falling edge where outputs are stable
    task automatic tick();
        ready_prev = wb_ready;
        @(negedge clk);
        check_wb();
    endtask

    task automatic check_ptrs();
        pos_t used;
        used = m_tail - m_head;
        expect_value("lq_tail_o", lq_tail, m_tail);
        expect_value("lq_full_o", lq_full, (LQ_DEPTH - int'(used)) < LQ_BANKS);
    endtask

    task automatic dispatch(int n);
        int i;
        expect_true(!lq_full, "dispatch attempted while the queue was full");
        expect_value("lq_tail_o", lq_tail, m_tail);
        dis_num = CNT_W'(n);
        for (int k = 0; k < n; k++) begin
            i = int'(m_tail[LQ_IDX_W-1:0]);
            m_valid[i]    = 1'b1;
            m_issued[i]   = 1'b0;
            m_miss[i]     = 1'b0;
            m_refilled[i] = 1'b0;
            m_written[i]  = 1'b0;
            m_pos[i]      = m_tail;
            m_tail        = m_tail + 1'b1;
        end
        tick();
        dis_num = '0;
        check_ptrs();
    endtask

    task automatic commit(int n);
        commit_num = CNT_W'(n);
        for (int k = 0; k < n; k++) begin
            m_valid[int'(m_head[LQ_IDX_W-1:0])] = 1'b0;
            m_head = m_head + 1'b1;
        end
        tick();
        commit_num = '0;
        check_ptrs();
    endtask

    task automatic dispatch_many(int n);
        for (int left = n; left > 0; left -= LQ_BANKS) begin
            dispatch(left > LQ_BANKS ? LQ_BANKS : left);
        end
    endtask

    task automatic commit_many(int n);
        for (int left = n; left > 0; left -= LQ_BANKS) begin
            commit(left > LQ_BANKS ? LQ_BANKS : left);
        end
    endtask

    task automatic issue_load(int pos, waddr_t addr, logic [WORD_BYTES-1:0] mask, logic miss);
        int b;
        b = pos % LQ_BANKS;
        issue[b]      = '0;
        issue[b].en   = 1'b1;
        issue[b].slot = SLOT_W'(pos / LQ_BANKS);
        issue[b].addr = addr;
        issue[b].mask = mask;
        issue[b].miss = miss;
        issue[b].rd   = REG_W'($random(seed));
        m_issued[pos] = 1'b1;
        m_miss[pos]   = miss;
        m_addr[pos]   = addr;
        m_mask[pos]   = mask;
        m_rd[pos]     = issue[b].rd;
        tick();
        issue[b] = '0;
    endtask

    task automatic refill_load(int pos);
        int b;
        b = pos % LQ_BANKS;
        refill[b].en    = 1'b1;
        refill[b].slot  = SLOT_W'(pos / LQ_BANKS);
        refill[b].data  = {$random(seed), $random(seed)};
        m_data[pos]     = refill[b].data;
        m_refilled[pos] = 1'b1;
        tick();
        refill[b] = '0;
    endtask

    task automatic wait_drain();
        for (int n = 0; n < 40 && waiting_count(-1) > 0; n++) begin
            tick();
        end
        expect_true(waiting_count(-1) == 0, "waiting loads were not written back in time");
        // a few more cycles to catch duplicates
        repeat (4) tick();
    endtask

    // oldest issued load at or after the store with overlapping bytes
    task automatic model_vio(pos_t st_pos, waddr_t addr, logic [WORD_BYTES-1:0] mask,
                             output logic found, output pos_t pos);
        pos_t st_age;
        pos_t tail_age;
        pos_t p;
        int   i;
        found    = 1'b0;
        pos      = '0;
        tail_age = m_tail - m_head;
        st_age   = st_pos - m_head;
        if (st_age > tail_age) begin
            st_age = '0;
        end
        for (int k = int'(st_age); k < int'(tail_age) && !found; k++) begin
            p = m_head + pos_t'(k);
            i = int'(p[LQ_IDX_W-1:0]);
            if (m_valid[i] && m_issued[i] && m_addr[i] == addr && (m_mask[i] & mask) != '0) begin
                found = 1'b1;
                pos   = p;
            end
        end
    endtask

    task automatic store_check(pos_t st_pos, waddr_t addr, logic [WORD_BYTES-1:0] mask,
                               logic want_hit);
        logic found;
        pos_t pos;
        model_vio(st_pos, addr, mask, found, pos);
        st.en     = 1'b1;
        st.lq_idx = lq_idx_t'(st_pos);
        st.addr   = addr;
        st.mask   = mask;
        tick();
        st = '0;
        expect_value("vio_o.en", vio.en, 1'b0);
        tick();
        expect_value("vio_o.en", vio.en, want_hit);
        if (found) begin
            expect_value("vio_o.lq_idx", vio.lq_idx, pos);
        end
        tick();
        expect_value("vio_o.en", vio.en, 1'b0);
    endtask

    task automatic test_dispatch_full();
        repeat (7) dispatch(2);
        dispatch(1);
        expect_true(lq_full, "queue not full with one entry free");
        commit(2);
        commit_many(13);
    endtask

    task automatic test_writeback();
        int base;
        int start;
        base  = int'(m_tail[LQ_IDX_W-1:0]);
        start = wb_seen;
        dispatch_many(4);
        issue_load(qpos(base, 0), waddr_t'($random(seed)), 8'hff, 1'b1);
        issue_load(qpos(base, 1), waddr_t'($random(seed)), 8'h0f, 1'b1);
        issue_load(qpos(base, 2), waddr_t'($random(seed)), 8'hff, 1'b0);
        issue_load(qpos(base, 3), waddr_t'($random(seed)), 8'h30, 1'b1);
        refill_load(qpos(base, 0));
        refill_load(qpos(base, 1));
        refill_load(qpos(base, 3));
        wait_drain();
        expect_value("writeback count", wb_seen - start, 3);
        commit_many(4);
    endtask

    task automatic test_backpressure();
        int base;
        int start;
        base  = int'(m_tail[LQ_IDX_W-1:0]);
        start = wb_seen;
        dispatch_many(4);
        for (int k = 0; k < 4; k++) begin
            issue_load(qpos(base, k), waddr_t'($random(seed)), 8'hff, 1'b1);
        end
        wb_ready = '0;
        for (int k = 0; k < 4; k++) begin
            refill_load(qpos(base, k));
        end
        repeat (6) tick();
        expect_value("waiting loads", waiting_count(-1), 4);
        // release bank 0 only
        wb_ready = 2'b01;
        repeat (6) tick();
        expect_value("waiting loads in bank 0", waiting_count(0), 0);
        expect_value("waiting loads in bank 1", waiting_count(1), 2);
        wb_ready = 2'b11;
        wait_drain();
        expect_value("writeback count", wb_seen - start, 4);
        commit_many(4);
    endtask

    task automatic test_violation();
        int     base;
        waddr_t a;
        pos_t   st_pos;
        base = int'(m_tail[LQ_IDX_W-1:0]);
        a    = waddr_t'($random(seed));
        dispatch(2);
        st_pos = m_tail;
        dispatch_many(4);
        issue_load(qpos(base, 0), a, 8'h0f, 1'b0);
        issue_load(qpos(base, 1), a, 8'hff, 1'b0);
        issue_load(qpos(base, 2), a, 8'hf0, 1'b0);
        issue_load(qpos(base, 3), a ^ waddr_t'(1), 8'hff, 1'b0);
        issue_load(qpos(base, 4), a, 8'h01, 1'b0);
        // the last load stays unissued
        store_check(st_pos, a, 8'h0f, 1'b1);
        store_check(st_pos, a, 8'hf0, 1'b1);
        store_check(st_pos, a ^ waddr_t'(1), 8'h0f, 1'b1);
        store_check(st_pos, a ^ waddr_t'(2), 8'hff, 1'b0);
        store_check(m_tail - 1'b1, a, 8'hff, 1'b0);
        store_check(m_tail, a, 8'hff, 1'b0);
        commit_many(6);
    endtask

    task automatic test_vio_wrap();
        int     base;
        waddr_t a;
        pos_t   st_pos;
        base = int'(m_tail[LQ_IDX_W-1:0]);
        a    = waddr_t'($random(seed));
        dispatch(1);
        st_pos = m_tail;
        dispatch_many(5);
        issue_load(qpos(base, 0), a, 8'hff, 1'b0);
        issue_load(qpos(base, 2), a, 8'h80, 1'b0);
        issue_load(qpos(base, 3), a, 8'h01, 1'b0);
        issue_load(qpos(base, 4), a, 8'h03, 1'b0);
        issue_load(qpos(base, 5), a, 8'hff, 1'b0);
        store_check(st_pos, a, 8'hff, 1'b1);
        store_check(st_pos, a, 8'h01, 1'b1);
        store_check(st_pos, a, 8'h02, 1'b1);
        // store now behind head so every live load is younger
        commit_many(2);
        store_check(st_pos, a, 8'h01, 1'b1);
        commit_many(4);
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst        = 1'b0;
        dis_num    = '0;
        commit_num = '0;
        issue      = '0;
        refill     = '0;
        wb_ready   = 2'b11;
        ready_prev = 2'b11;
        st         = '0;
        value_errs = 0;
        other_errs = 0;
        wb_seen    = 0;
        m_head     = '0;
        m_tail     = '0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            m_valid[i]    = 1'b0;
            m_issued[i]   = 1'b0;
            m_miss[i]     = 1'b0;
            m_refilled[i] = 1'b0;
            m_written[i]  = 1'b0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b1;
        tick();
        expect_value("wb_o[0].en", wb[0].en, 1'b0);
        expect_value("wb_o[1].en", wb[1].en, 1'b0);
        expect_value("vio_o.en", vio.en, 1'b0);
        check_ptrs();

        test_dispatch_full();
        test_writeback();
        test_backpressure();
        test_violation();
        test_vio_wrap();

        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- load_queue.f
src/lq_pkg.sv
src/lq_alloc.sv
src/lq_bank.sv
src/lq_drain.sv
src/load_queue.sv
tests/tb_clock.sv
tests/load_queue_tb.sv

//--- run.sh
#!/bin/sh
# build and run the load queue testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal -f load_queue.f \
    --top-module load_queue_tb -o load_queue_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/load_queue_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0
